// File: filelist.f
verilog/conv_pkg.sv
verilog/axil_pkg.sv
verilog/adder_tree_pipeline.sv
verilog/vector_conv.sv
verilog/weight_regs.sv
verilog/row_window.sv
verilog/conv2d_core.sv
verilog/conv2d_top.sv
bench/conv2d_sva.sv
bench/conv2d_tb.sv

// File: Bender.yml
package:
  name: conv2d

sources:
  - verilog/conv_pkg.sv
  - verilog/axil_pkg.sv
  - verilog/adder_tree_pipeline.sv
  - verilog/vector_conv.sv
  - verilog/weight_regs.sv
  - verilog/row_window.sv
  - verilog/conv2d_core.sv
  - verilog/conv2d_top.sv
  - target: test
    files:
      - bench/conv2d_sva.sv
      - bench/conv2d_tb.sv

// File: bench/conv2d_tb.sv
/*
 * Testbench for conv2d_top
 *   - clock, reset and cycle watchdog
 *   - AXI4-Lite write and read tasks
 *   - Galois LFSR and reference model of the 2D valid convolution
 *   - output monitor and directed tests
 */

`timescale 1ns/1ps

module conv2d_tb;

    localparam int LENGTH    = 10;
    localparam int COV_SIZE  = 3;
    localparam int NW        = COV_SIZE * COV_SIZE;
    localparam int OUT_LEN   = LENGTH - COV_SIZE + 1;
    localparam int OUT_SUM_W = conv_pkg::PRODUCT_W + 2 * $clog2(COV_SIZE);
    localparam int LATENCY   = 7;  // Closing row to output row

    // Run length bound
    localparam int ROWS_DRIVEN = 29;
    localparam int BUS_OPS     = 78;
    localparam int TIMEOUT     = 2 * ROWS_DRIVEN + 8 * BUS_OPS + 400;

    typedef conv_pkg::pixel_t [LENGTH-1:0]     row_t;
    typedef logic [OUT_LEN-1:0][OUT_SUM_W-1:0] sums_t;

    typedef struct packed {
        conv_pkg::row_ctrl_t ctrl;
        sums_t               sums;
        logic [31:0]         cyc;   // Cycle the closing row was driven
    } expect_t;

    logic                clk = 1'b0;
    logic                rst_n;
    axil_pkg::axil_req_t axil_req;
    axil_pkg::axil_rsp_t axil_rsp;
    conv_pkg::row_ctrl_t row_ctrl;
    row_t                row_pixels;
    conv_pkg::row_ctrl_t out_ctrl;
    sums_t               out_sums;

    // Reference model state
    conv_pkg::weight_t kernel [NW];
    row_t              win [COV_SIZE];  // Index 0 the oldest row
    int                frame_rows;      // Rows since the last sof
    expect_t           exp_q [$];

    logic [15:0] lfsr      = 16'd52;
    logic [31:0] cycle_cnt = '0;
    int          check_cnt = 0;
    int          error_cnt = 0;
    int          out_rows  = 0;
    sums_t       last_sums;

    conv2d_top #(.LENGTH(LENGTH), .COV_SIZE(COV_SIZE)) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .axil       (axil_req),
        .axil_rsp   (axil_rsp),
        .row_ctrl   (row_ctrl),
        .row_pixels (row_pixels),
        .out_ctrl   (out_ctrl),
        .out_sums   (out_sums)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////
    // Random source and checks
    ////////////////////////////////

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic row_t rand_row();
        row_t r;
        for (int p = 0; p < LENGTH; p++) r[p] = rand_bits(8);
        return r;
    endfunction

    task automatic check_value(input string name, input longint got, input longint expected);
        check_cnt++;
        assert (got == expected) else begin
            error_cnt++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_cnt++;
        assert (cond) else begin
            error_cnt++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    ////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        logic aw_go, w_go;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'h1;
        axil_req.bready  = 1'b0;
        while (axil_req.awvalid || axil_req.wvalid) begin
            aw_go = axil_rsp.awready;  // Transfer on the coming edge
            w_go  = axil_rsp.wready;
            @(negedge clk);
            if (aw_go) axil_req.awvalid = 1'b0;
            if (w_go)  axil_req.wvalid  = 1'b0;
        end
        while (!axil_rsp.bvalid) @(negedge clk);
        @(negedge clk);  // Response left waiting for one cycle
        check_true(axil_rsp.bvalid, "bvalid dropped before bready");
        check_true(!axil_rsp.awready && !axil_rsp.wready,
                   "write channels ready while a write response waits");
        resp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic ar_go;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b0;
        while (axil_req.arvalid) begin
            ar_go = axil_rsp.arready;
            @(negedge clk);
            if (ar_go) axil_req.arvalid = 1'b0;
        end
        while (!axil_rsp.rvalid) @(negedge clk);
        @(negedge clk);  // Read data left waiting for one cycle
        check_true(axil_rsp.rvalid, "rvalid dropped before rready");
        check_true(!axil_rsp.arready, "read address ready while read data waits");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic write_weight(input int n, input conv_pkg::weight_t w);
        logic [1:0] resp;
        axil_write(8'(4 * n), 32'(w), resp);
        check_value("bresp", resp, axil_pkg::RESP_OKAY);
        kernel[n] = w;
    endtask

    task automatic load_random_kernel();
        for (int n = 0; n < NW; n++) write_weight(n, rand_bits(8));
    endtask

    // Every weight register against the model's copy
    task automatic read_check_bank();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int n = 0; n < NW; n++) begin
            axil_read(8'(4 * n), data, resp);
            check_value($sformatf("weight %0d", n), data, kernel[n]);
            check_value("rresp", resp, axil_pkg::RESP_OKAY);
        end
    endtask

    ////////////////////////////////
    // Row driver and model
    ////////////////////////////////

    task automatic send_row(input row_t pix, input logic sof, input logic eof);
        expect_t e;
        int      acc;
        @(negedge clk);
        row_ctrl.valid = 1'b1;
        row_ctrl.sof   = sof;
        row_ctrl.eof   = eof;
        row_pixels     = pix;
        frame_rows = sof ? 1 : frame_rows + 1;
        for (int k = 0; k < COV_SIZE - 1; k++) win[k] = win[k+1];
        win[COV_SIZE-1] = pix;
        if (frame_rows >= COV_SIZE) begin  // At least the COV_SIZE-th row of the frame
            for (int c = 0; c < OUT_LEN; c++) begin
                acc = 0;
                for (int k = 0; k < COV_SIZE; k++) begin
                    for (int j = 0; j < COV_SIZE; j++) begin
                        acc += int'(win[k][c+j]) * int'(kernel[k*COV_SIZE+j]);
                    end
                end
                e.sums[c] = OUT_SUM_W'(acc);
            end
            e.ctrl.valid = 1'b1;
            e.ctrl.sof   = (frame_rows == COV_SIZE);  // First window of the frame
            e.ctrl.eof   = eof;
            e.cyc        = cycle_cnt;
            exp_q.push_back(e);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            row_ctrl = '0;
        end
    endtask

    task automatic send_frame(input int rows, input logic gaps);
        for (int r = 0; r < rows; r++) begin
            send_row(rand_row(), r == 0, r == rows - 1);
            if (gaps) idle_cycles(1 + rand_bits(2));
        end
    endtask

    task automatic wait_drain();
        idle_cycles(1);
        while (exp_q.size() != 0) @(negedge clk);
        idle_cycles(2);
    endtask

    // Output rows against the expected queue
    always @(negedge clk) begin : monitor
        expect_t e;
        if (rst_n && out_ctrl.valid) begin
            out_rows++;
            last_sums = out_sums;
            check_true(exp_q.size() != 0, "output row arrived with no row expected");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_value("out_ctrl.sof", out_ctrl.sof, e.ctrl.sof);
                check_value("out_ctrl.eof", out_ctrl.eof, e.ctrl.eof);
                check_value("latency", cycle_cnt - e.cyc, LATENCY);
                for (int c = 0; c < OUT_LEN; c++) begin
                    check_value($sformatf("out_sums[%0d]", c), out_sums[c], e.sums[c]);
                end
            end
        end
    end

    ////////////////////////////////
    // Directed tests
    ////////////////////////////////

    task automatic test_reset_state();
        repeat (20) begin
            @(negedge clk);
            check_value("out_ctrl.valid", out_ctrl.valid, 0);
            check_value("bvalid", axil_rsp.bvalid, 0);
            check_value("rvalid", axil_rsp.rvalid, 0);
            check_value("awready", axil_rsp.awready, 1);
            check_value("wready", axil_rsp.wready, 1);
            check_value("arready", axil_rsp.arready, 1);
        end
        read_check_bank();  // All zero after reset
    endtask

    task automatic test_weight_regs();
        logic [7:0]  bad [3] = '{8'd36, 8'd40, 8'd252};
        logic [31:0] data;
        logic [1:0]  resp;
        load_random_kernel();
        read_check_bank();
        for (int i = 0; i < 3; i++) begin
            axil_write(bad[i], 32'hA5, resp);
            check_value("bresp", resp, axil_pkg::RESP_SLVERR);
            axil_read(bad[i], data, resp);
            check_value("rresp", resp, axil_pkg::RESP_SLVERR);
            check_value("rdata", data, 0);
        end
        read_check_bank();  // Bank untouched by the bad writes
    endtask

    task automatic test_identity();
        int start;
        for (int n = 0; n < NW; n++) write_weight(n, (n == NW / 2) ? 8'd1 : 8'd0);
        start = out_rows;
        send_frame(5, 1'b0);
        wait_drain();
        check_value("output rows", out_rows - start, 3);
    endtask

    task automatic test_random_frames();
        int start;
        load_random_kernel();
        start = out_rows;
        send_frame(5, 1'b0);
        send_frame(3, 1'b0);  // Short frame right after, old window dropped
        send_frame(6, 1'b0);
        wait_drain();
        check_value("output rows", out_rows - start, 8);
    endtask

    task automatic test_saturation();
        row_t full;
        full = '1;
        for (int n = 0; n < NW; n++) write_weight(n, 8'hFF);
        for (int r = 0; r < 4; r++) send_row(full, r == 0, r == 3);
        wait_drain();
        for (int c = 0; c < OUT_LEN; c++) begin
            check_value($sformatf("out_sums[%0d]", c), last_sums[c], 9 * 255 * 255);
        end
    endtask

    task automatic test_idle_gaps();
        int start;
        load_random_kernel();
        start = out_rows;
        send_frame(6, 1'b1);
        wait_drain();
        check_value("output rows", out_rows - start, 4);
    endtask

    initial begin
        rst_n      = 1'b0;
        axil_req   = '0;
        row_ctrl   = '0;
        row_pixels = '0;
        frame_rows = 0;
        for (int n = 0; n < NW; n++) kernel[n] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_weight_regs();
        test_identity();
        test_random_frames();
        test_saturation();
        test_idle_gaps();

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/conv2d_sva.sv
/*
 * Concurrent assertions bound to conv2d_top
 *   - bvalid and rvalid held until accepted
 *   - output row exactly at the pipeline latency after a closing row
 *   - no valid outputs during reset
 */

`timescale 1ns/1ps

module conv2d_sva #(
    parameter int COV_SIZE = 3
) (
    input logic                clk,
    input logic                rst_n,
    input axil_pkg::axil_req_t axil,
    input axil_pkg::axil_rsp_t axil_rsp,
    input conv_pkg::row_ctrl_t row_ctrl,
    input conv_pkg::row_ctrl_t out_ctrl
);

    localparam int LATENCY = 3 + 2 * $clog2(COV_SIZE);

    logic [3:0] cnt_q, cnt_next;  // Rows since sof, saturating
    logic       closes_window;

    always_comb begin
        cnt_next = cnt_q;
        if (row_ctrl.valid) begin
            if (row_ctrl.sof)                 cnt_next = 4'd1;
            else if (cnt_q < 4'(COV_SIZE))    cnt_next = cnt_q + 4'd1;
        end
    end

    assign closes_window = row_ctrl.valid && (cnt_next == 4'(COV_SIZE));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) cnt_q <= '0;
        else        cnt_q <= cnt_next;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else $error("bvalid dropped or bresp changed before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid dropped or rdata changed before rready");

    a_window_out: assert property (@(posedge clk) disable iff (!rst_n)
        closes_window |-> ##LATENCY out_ctrl.valid)
        else $error("no output row at the expected latency after a full window");

    a_no_stray_out: assert property (@(posedge clk) disable iff (!rst_n)
        out_ctrl.valid |-> $past(closes_window, LATENCY))
        else $error("output row without a matching full window");

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !out_ctrl.valid && !axil_rsp.bvalid && !axil_rsp.rvalid)
        else $error("valid output while reset is active");

endmodule

bind conv2d_top conv2d_sva #(.COV_SIZE(COV_SIZE)) sva_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil     (axil),
    .axil_rsp (axil_rsp),
    .row_ctrl (row_ctrl),
    .out_ctrl (out_ctrl)
);

// File: verilog/conv2d_top.sv
/*
 * conv2d_top
 *   AXI4-Lite weight bank and the 2D convolution core.
 */

`timescale 1ns/1ps

module conv2d_top #(
    parameter  int LENGTH    = 10,
    parameter  int COV_SIZE  = 3,
    localparam int L         = $clog2(COV_SIZE),
    localparam int OUT_LEN   = LENGTH - COV_SIZE + 1,
    localparam int OUT_SUM_W = conv_pkg::PRODUCT_W + 2 * L
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Configuration bus
    input  axil_pkg::axil_req_t               axil,
    output axil_pkg::axil_rsp_t               axil_rsp,

    // Pixel rows in, convolution rows out
    input  conv_pkg::row_ctrl_t               row_ctrl,
    input  conv_pkg::pixel_t [LENGTH-1:0]     row_pixels,
    output conv_pkg::row_ctrl_t               out_ctrl,
    output logic [OUT_LEN-1:0][OUT_SUM_W-1:0] out_sums
);

    conv_pkg::weight_t [COV_SIZE*COV_SIZE-1:0] weights;

    weight_regs #(.COV_SIZE(COV_SIZE)) weight_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil     (axil),
        .axil_rsp (axil_rsp),
        .weights  (weights)
    );

    conv2d_core #(.LENGTH(LENGTH), .COV_SIZE(COV_SIZE)) core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_ctrl   (row_ctrl),
        .row_pixels (row_pixels),
        .weights    (weights),
        .out_ctrl   (out_ctrl),
        .out_sums   (out_sums)
    );

endmodule

// File: verilog/conv2d_core.sv
/*
 * conv2d_core
 *   Row window, one vector_conv per kernel row and one column
 *   adder tree per output column. Latency 3 + 2*clog2(COV_SIZE).
 */

`timescale 1ns/1ps

module conv2d_core #(
    parameter  int LENGTH    = 10,
    parameter  int COV_SIZE  = 3,
    localparam int L         = $clog2(COV_SIZE),
    localparam int OUT_LEN   = LENGTH - COV_SIZE + 1,
    localparam int ROW_SUM_W = conv_pkg::PRODUCT_W + L,
    localparam int OUT_SUM_W = ROW_SUM_W + L
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  conv_pkg::row_ctrl_t                       row_ctrl,
    input  conv_pkg::pixel_t [LENGTH-1:0]             row_pixels,
    input  conv_pkg::weight_t [COV_SIZE*COV_SIZE-1:0] weights,
    output conv_pkg::row_ctrl_t                       out_ctrl,
    output logic [OUT_LEN-1:0][OUT_SUM_W-1:0]         out_sums
);

    typedef logic [ROW_SUM_W-1:0] row_sum_t;
    typedef logic [OUT_SUM_W-1:0] out_sum_t;

    conv_pkg::row_ctrl_t                          win_ctrl;
    conv_pkg::pixel_t [COV_SIZE-1:0][LENGTH-1:0]  win_rows;
    conv_pkg::row_ctrl_t                          conv_ctrl [COV_SIZE];  // Identical per row
    row_sum_t [OUT_LEN-1:0]                       row_sums  [COV_SIZE];
    row_sum_t [COV_SIZE-1:0]                      col_terms [OUT_LEN];

    row_window #(.LENGTH(LENGTH), .COV_SIZE(COV_SIZE)) window_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_ctrl   (row_ctrl),
        .row_pixels (row_pixels),
        .win_ctrl   (win_ctrl),
        .win_rows   (win_rows)
    );

    for (genvar k = 0; k < COV_SIZE; k++) begin : g_krow
        vector_conv #(.LENGTH(LENGTH), .COV_SIZE(COV_SIZE)) conv_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .ctrl         (win_ctrl),
            .pixels       (win_rows[k]),
            .weights      (weights[k*COV_SIZE +: COV_SIZE]),  // Kernel row k
            .ctrl_out     (conv_ctrl[k]),
            .partial_sums (row_sums[k])
        );
    end

    //////////////////////////////
    // Column sums
    //////////////////////////////

    for (genvar c = 0; c < OUT_LEN; c++) begin : g_col
        for (genvar k = 0; k < COV_SIZE; k++) begin : g_term
            assign col_terms[c][k] = row_sums[k][c];
        end
        adder_tree_pipeline #(
            .N        (COV_SIZE),
            .addend_t (row_sum_t),
            .sum_t    (out_sum_t)
        ) tree_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .addends (col_terms[c]),
            .sum     (out_sums[c])
        );
    end

    // Match the column tree latency
    if (L == 0) begin : g_no_delay
        assign out_ctrl = conv_ctrl[0];
    end else begin : g_delay
        conv_pkg::row_ctrl_t pipe [L];
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int d = 0; d < L; d++) pipe[d] <= '0;
            end else begin
                pipe[0] <= conv_ctrl[0];
                for (int d = 1; d < L; d++) pipe[d] <= pipe[d-1];
            end
        end
        assign out_ctrl = pipe[L-1];
    end

endmodule

// File: verilog/row_window.sv
/*
 * row_window
 *   Shift buffer of the last COV_SIZE rows, index 0 the oldest.
 *   Counts rows since sof and flags a full window of the frame.
 */

`timescale 1ns/1ps

module row_window #(
    parameter int LENGTH   = 10,
    parameter int COV_SIZE = 3
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  conv_pkg::row_ctrl_t                         row_ctrl,
    input  conv_pkg::pixel_t [LENGTH-1:0]               row_pixels,
    output conv_pkg::row_ctrl_t                         win_ctrl,
    output conv_pkg::pixel_t [COV_SIZE-1:0][LENGTH-1:0] win_rows
);

    localparam int CNT_W = $clog2(COV_SIZE + 1);

    conv_pkg::pixel_t [COV_SIZE-1:0][LENGTH-1:0] rows_q;
    logic [CNT_W-1:0] cnt_q, cnt_next;
    logic             full, first;

    // Rows seen in the current frame, saturating at COV_SIZE
    always_comb begin
        cnt_next = cnt_q;
        if (row_ctrl.valid) begin
            if (row_ctrl.sof)                  cnt_next = CNT_W'(1);  // Restart on a new frame
            else if (cnt_q < CNT_W'(COV_SIZE)) cnt_next = cnt_q + 1'b1;
        end
    end

    assign full  = row_ctrl.valid && (cnt_next == CNT_W'(COV_SIZE));
    assign first = full && (row_ctrl.sof || cnt_q != CNT_W'(COV_SIZE));

    always_ff @(posedge clk) begin
        if (row_ctrl.valid) begin
            for (int k = 0; k < COV_SIZE - 1; k++) rows_q[k] <= rows_q[k+1];
            rows_q[COV_SIZE-1] <= row_pixels;  // Newest row on top
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q    <= '0;
            win_ctrl <= '0;
        end else begin
            cnt_q          <= cnt_next;
            win_ctrl.valid <= full;
            win_ctrl.sof   <= first;
            win_ctrl.eof   <= full && row_ctrl.eof;
        end
    end

    assign win_rows = rows_q;

endmodule

// File: verilog/weight_regs.sv
/*
 * weight_regs
 *   AXI4-Lite slave holding COV_SIZE*COV_SIZE kernel weights.
 *   Word n holds weight n in its low byte, row-major order.
 *   Out of range accesses answer SLVERR, reads there return zero.
 */

`timescale 1ns/1ps

module weight_regs #(
    parameter int COV_SIZE = 3
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  axil_pkg::axil_req_t                       axil,
    output axil_pkg::axil_rsp_t                       axil_rsp,
    output conv_pkg::weight_t [COV_SIZE*COV_SIZE-1:0] weights
);

    localparam int NW    = COV_SIZE * COV_SIZE;
    localparam int IDX_W = axil_pkg::AXIL_ADDR_W - 2;  // Word index bits

    conv_pkg::weight_t [NW-1:0] bank;

    // Write side holding registers
    logic              aw_held, w_held;
    logic [IDX_W-1:0]  aw_idx_q;
    conv_pkg::weight_t w_data_q;
    logic              w_lane0_q;  // wstrb bit of byte lane 0
    logic              bvalid_q;
    logic [1:0]        bresp_q;

    // Read side
    logic                                rvalid_q;
    logic [axil_pkg::AXIL_DATA_W-1:0]    rdata_q;
    logic [1:0]                          rresp_q;
    logic [IDX_W-1:0]                    ar_idx;

    logic aw_ok, w_ok, ar_ok, wr_hit, rd_hit, commit;

    assign aw_ok  = axil.awvalid && !aw_held && !bvalid_q;
    assign w_ok   = axil.wvalid && !w_held && !bvalid_q;
    assign ar_ok  = axil.arvalid && !rvalid_q;
    assign commit = aw_held && w_held && !bvalid_q;
    assign ar_idx = axil.araddr[axil_pkg::AXIL_ADDR_W-1:2];
    assign wr_hit = 32'(aw_idx_q) < NW;
    assign rd_hit = 32'(ar_idx) < NW;

    always_ff @(posedge clk) begin
        if (aw_ok) aw_idx_q <= axil.awaddr[axil_pkg::AXIL_ADDR_W-1:2];
        if (w_ok) begin
            w_data_q  <= axil.wdata[conv_pkg::WEIGHT_W-1:0];
            w_lane0_q <= axil.wstrb[0];
        end
        if (commit) bresp_q <= wr_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        if (ar_ok) begin
            rdata_q <= rd_hit ? axil_pkg::AXIL_DATA_W'(bank[ar_idx]) : '0;
            rresp_q <= rd_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    //////////////////////////////
    // Handshake state and bank
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            bank     <= '0;
        end else begin
            if (aw_ok) aw_held <= 1'b1;
            if (w_ok)  w_held  <= 1'b1;
            if (commit) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                bvalid_q <= 1'b1;
                if (wr_hit && w_lane0_q) bank[aw_idx_q] <= w_data_q;
            end else if (bvalid_q && axil.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_ok) rvalid_q <= 1'b1;
            else if (rvalid_q && axil.rready) rvalid_q <= 1'b0;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = !aw_held && !bvalid_q;
        axil_rsp.wready  = !w_held && !bvalid_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = !rvalid_q;  // Low while read data waits
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    assign weights = bank;

endmodule

// File: verilog/vector_conv.sv
/*
 * vector_conv
 *   One dimensional convolution of a pixel row with one kernel row.
 *   Input register, multiply register, then one adder tree per
 *   output column. Control follows the data at 2+clog2(COV_SIZE).
 */

`timescale 1ns/1ps

module vector_conv #(
    parameter  int LENGTH    = 10,
    parameter  int COV_SIZE  = 3,
    localparam int L         = $clog2(COV_SIZE),
    localparam int OUT_LEN   = LENGTH - COV_SIZE + 1,
    localparam int ROW_SUM_W = conv_pkg::PRODUCT_W + L
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  conv_pkg::row_ctrl_t                  ctrl,
    input  conv_pkg::pixel_t [LENGTH-1:0]        pixels,
    input  conv_pkg::weight_t [COV_SIZE-1:0]     weights,
    output conv_pkg::row_ctrl_t                  ctrl_out,
    output logic [OUT_LEN-1:0][ROW_SUM_W-1:0]    partial_sums
);

    localparam int DELAY = 2 + L;

    typedef logic [ROW_SUM_W-1:0] row_sum_t;

    conv_pkg::pixel_t [LENGTH-1:0]      pix_q;            // Cuts the path from the window
    conv_pkg::product_t [COV_SIZE-1:0]  prod [OUT_LEN];   // One product per tap
    conv_pkg::row_ctrl_t                ctrl_pipe [DELAY];

    always_ff @(posedge clk) begin
        pix_q <= pixels;
        for (int i = 0; i < OUT_LEN; i++) begin
            for (int j = 0; j < COV_SIZE; j++) begin
                prod[i][j] <= conv_pkg::product_t'(pix_q[i+j]) * weights[j];
            end
        end
    end

    // Control shift register, same depth as the data path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < DELAY; d++) ctrl_pipe[d] <= '0;
        end else begin
            ctrl_pipe[0] <= ctrl;
            for (int d = 1; d < DELAY; d++) ctrl_pipe[d] <= ctrl_pipe[d-1];
        end
    end

    assign ctrl_out = ctrl_pipe[DELAY-1];

    for (genvar i = 0; i < OUT_LEN; i++) begin : g_col
        adder_tree_pipeline #(
            .N        (COV_SIZE),
            .addend_t (conv_pkg::product_t),
            .sum_t    (row_sum_t)
        ) tree_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .addends (prod[i]),
            .sum     (partial_sums[i])
        );
    end

endmodule

// File: verilog/adder_tree_pipeline.sv
/*
 * adder_tree_pipeline
 *   Registered binary adder tree over N addends of type addend_t.
 *   Odd counts are padded with zeros, each level adds one bit,
 *   result resized to sum_t. Latency is clog2(N) cycles.
 */

`timescale 1ns/1ps

module adder_tree_pipeline #(
    parameter int  N        = 3,
    parameter type addend_t = logic [15:0],
    parameter type sum_t    = logic [17:0]
) (
    input  logic              clk,
    input  logic              rst_n,
    input  addend_t [N-1:0]   addends,
    output sum_t              sum
);

    localparam int L   = (N > 1) ? $clog2(N) : 0;  // Tree depth
    localparam int A_W = $bits(addend_t);
    localparam int P   = 1 << L;                   // Leaves after zero fill

    for (genvar lv = 0; lv <= L; lv++) begin : g_lvl
        localparam int W   = A_W + lv;   // One carry bit per level
        localparam int CNT = P >> lv;

        logic [W-1:0] node [CNT];

        if (lv == 0) begin : g_leaf
            for (genvar i = 0; i < CNT; i++) begin : g_fill
                if (i < N) begin : g_data
                    assign node[i] = addends[i];
                end else begin : g_zero
                    assign node[i] = '0;  // Pad to a power of two
                end
            end
        end else begin : g_add
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < CNT; i++) node[i] <= '0;
                end else begin
                    for (int i = 0; i < CNT; i++) begin
                        node[i] <= W'(g_lvl[lv-1].node[2*i]) + W'(g_lvl[lv-1].node[2*i+1]);
                    end
                end
            end
        end
    end

    assign sum = sum_t'(g_lvl[L].node[0]);  // Root of the tree

endmodule

// File: verilog/axil_pkg.sv
/*
 * AXI4-Lite configuration bus definitions
 *   - address and data widths
 *   - response codes
 *   - master request and slave response structs
 */

package axil_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

// File: verilog/conv_pkg.sv
/*
 * Pixel path definitions for the 2D convolution engine
 *   - element widths for pixels, weights and products
 *   - pixel_t, weight_t, product_t
 *   - row_ctrl_t, control flags that travel with each row
 */

package conv_pkg;

    //////////////////////////////
    // Element widths
    //////////////////////////////

    localparam int PIXEL_W   = 8;
    localparam int WEIGHT_W  = 8;
    localparam int PRODUCT_W = PIXEL_W + WEIGHT_W;  // Full unsigned product

    //////////////////////////////
    // Element types
    //////////////////////////////

    typedef logic [PIXEL_W-1:0]   pixel_t;    // Unsigned pixel
    typedef logic [WEIGHT_W-1:0]  weight_t;   // Unsigned kernel weight
    typedef logic [PRODUCT_W-1:0] product_t;  // pixel_t * weight_t

    // Flags carried alongside a row through every pipeline stage
    typedef struct packed {
        logic valid;  // Row present this cycle
        logic sof;    // First row of a frame
        logic eof;    // Last row of a frame
    } row_ctrl_t;

    // Row sums grow by log2 of the kernel edge over a product,
    // output sums grow by the same amount once more

endpackage
